// ==== source/isaPkg.sv ====
package isaPkg;

	////////////////////////////////////////
	// Basic widths and words
	////////////////////////////////////////

	localparam int XLEN = 32;

	typedef logic [XLEN-1:0] word_t;
	typedef logic [4:0] regAddr_t;

	// Major opcodes handled by the core
	typedef enum logic [6:0] {
		OPCODE_LOAD    = 7'b0000011,
		OPCODE_ALU_IMM = 7'b0010011,
		OPCODE_STORE   = 7'b0100011,
		OPCODE_ALU_REG = 7'b0110011
	} opcode_t;

	// ALU operations, shared by register and immediate forms
	typedef enum logic [2:0] {
		FUNCT3_ADD  = 3'b000,
		FUNCT3_SLL  = 3'b001,
		FUNCT3_SLT  = 3'b010,
		FUNCT3_SLTU = 3'b011,
		FUNCT3_XOR  = 3'b100,
		FUNCT3_SRL  = 3'b101,
		FUNCT3_OR   = 3'b110,
		FUNCT3_AND  = 3'b111
	} funct3_t;

	// Word width code for LW and SW, same bits as SLT
	localparam funct3_t FUNCT3_WORD = FUNCT3_SLT;

	////////////////////////////////////////
	// Instruction formats
	////////////////////////////////////////

	typedef struct packed {
		logic [6:0] funct7;
		regAddr_t   rs2;
		regAddr_t   rs1;
		funct3_t    funct3;
		regAddr_t   rd;
		opcode_t    opcode;
	} rType_t;

	typedef struct packed {
		logic [11:0] imm;
		regAddr_t    rs1;
		funct3_t     funct3;
		regAddr_t    rd;
		opcode_t     opcode;
	} iType_t;

	typedef struct packed {
		logic [6:0] immHi;
		regAddr_t   rs2;
		regAddr_t   rs1;
		funct3_t    funct3;
		logic [4:0] immLo;
		opcode_t    opcode;
	} sType_t;

	// One instruction word seen through each format
	typedef union packed {
		rType_t rType;
		iType_t iType;
		sType_t sType;
	} instr_u;

endpackage

// ==== source/ctrlPkg.sv ====
package ctrlPkg;

	////////////////////////////////////////
	// Controller states
	////////////////////////////////////////

	typedef enum logic [3:0] {
		FETCH         = 4'd0,
		DECODE        = 4'd1,
		EXECUTE_R     = 4'd2,
		EXECUTE_I     = 4'd3,
		MEMORY        = 4'd4,
		MEMORY_STORE  = 4'd5,
		WRITEBACK     = 4'd6,
		WRITEBACK_MEM = 4'd7
	} ctrlState_t;

	////////////////////////////////////////
	// Datapath select codes
	////////////////////////////////////////

	typedef enum logic {
		ALU_SRC_A_PC  = 1'b0,
		ALU_SRC_A_RS1 = 1'b1
	} aluSrcA_t;

	typedef enum logic [1:0] {
		ALU_SRC_B_RS2  = 2'd0,
		ALU_SRC_B_FOUR = 2'd1,
		ALU_SRC_B_IMM  = 2'd2
	} aluSrcB_t;

	// Register file write data
	typedef enum logic {
		WB_SRC_ALU = 1'b0,
		WB_SRC_MEM = 1'b1
	} wbSrc_t;

	// Memory address source
	typedef enum logic {
		ADDR_SRC_PC  = 1'b0,
		ADDR_SRC_ALU = 1'b1
	} addrSrc_t;

endpackage

// ==== source/aluUnit.sv ====
`timescale 1ns/1ps

module aluUnit
	import isaPkg::*;
(
	input  word_t   a,
	input  word_t   b,
	input  funct3_t funct3,
	input  logic    altBit,
	input  logic    aluRegForm,
	input  logic    aluOverride,
	output word_t   result
);

	logic [4:0] shamt;

	assign shamt = b[4:0];

	always_comb begin
		if (aluOverride) begin
			// Address and PC+4 arithmetic
			result = a + b;
		end else begin
			case (funct3)
				FUNCT3_ADD: begin
					// Immediate adds never subtract
					if (aluRegForm && altBit) begin
						result = a - b;
					end else begin
						result = a + b;
					end
				end
				FUNCT3_SLL:  result = a << shamt;
				FUNCT3_SLT:  result = word_t'($signed(a) < $signed(b));
				FUNCT3_SLTU: result = word_t'(a < b);
				FUNCT3_XOR:  result = a ^ b;
				FUNCT3_SRL: begin
					if (altBit) begin
						result = word_t'($signed(a) >>> shamt);
					end else begin
						result = a >> shamt;
					end
				end
				FUNCT3_OR:   result = a | b;
				FUNCT3_AND:  result = a & b;
				default:     result = a + b;
			endcase
		end
	end

endmodule

// ==== source/registerFile.sv ====
`timescale 1ns/1ps

module registerFile
	import isaPkg::*;
(
	input  logic     clk,
	input  logic     arstN,
	input  logic     regWrite,
	input  regAddr_t rs1Addr,
	input  regAddr_t rs2Addr,
	input  regAddr_t rdAddr,
	input  word_t    rdData,
	output word_t    rs1Data,
	output word_t    rs2Data
);

	// x0 has no storage
	word_t regs [1:31];

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (regWrite && (rdAddr != '0)) begin
			regs[rdAddr] <= rdData;
		end
	end

	assign rs1Data = (rs1Addr == '0) ? '0 : regs[rs1Addr];
	assign rs2Data = (rs2Addr == '0) ? '0 : regs[rs2Addr];

	zeroReadsZero: assert property (@(posedge clk) disable iff (!arstN)
		((rs1Addr == '0) |-> (rs1Data == '0)) and ((rs2Addr == '0) |-> (rs2Data == '0)));

endmodule

// ==== source/mainController.sv ====
`timescale 1ns/1ps

module mainController
	import isaPkg::*, ctrlPkg::*;
(
	input  logic     clk,
	input  logic     arstN,
	input  opcode_t  opCode,
	input  funct3_t  funct3,
	output logic     pcWrite,
	output logic     irWrite,
	output logic     regWrite,
	output logic     memWe,
	output logic     aluOverride,
	output logic     aluRegForm,
	output aluSrcA_t aluSrcA,
	output aluSrcB_t aluSrcB,
	output addrSrc_t addrSrc,
	output wbSrc_t   wbSrc
);

	ctrlState_t state;
	ctrlState_t nextState;

	logic regForm;
	logic memOp;
	logic wordAccess;

	// Opcode classes
	assign regForm    = (opCode == OPCODE_ALU_REG);
	assign memOp      = (opCode == OPCODE_LOAD) || (opCode == OPCODE_STORE);
	// Byte and halfword widths fall back to a no-op
	assign wordAccess = (funct3 == FUNCT3_WORD);

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			state <= FETCH;
		end else begin
			state <= nextState;
		end
	end

	////////////////////////////////////////
	// Next state and outputs
	////////////////////////////////////////

	always_comb begin
		pcWrite   = 1'b0;
		irWrite   = 1'b0;
		regWrite  = 1'b0;
		memWe     = 1'b0;
		wbSrc     = WB_SRC_ALU;
		addrSrc   = ADDR_SRC_PC;
		nextState = state;

		// Operands held steady after execute so aluOut keeps its value
		aluSrcA     = ALU_SRC_A_RS1;
		aluSrcB     = regForm ? ALU_SRC_B_RS2 : ALU_SRC_B_IMM;
		aluOverride = memOp;
		aluRegForm  = regForm;

		case (state)
			FETCH: begin
				irWrite     = 1'b1;
				aluSrcA     = ALU_SRC_A_PC;
				aluSrcB     = ALU_SRC_B_FOUR;
				aluOverride = 1'b1;
				aluRegForm  = 1'b0;
				nextState   = DECODE;
			end
			DECODE: begin
				// PC takes PC+4 left in aluOut by fetch
				pcWrite = 1'b1;
				case (opCode)
					OPCODE_ALU_REG: nextState = EXECUTE_R;
					OPCODE_ALU_IMM: nextState = EXECUTE_I;
					OPCODE_LOAD:    nextState = wordAccess ? EXECUTE_I : FETCH;
					OPCODE_STORE:   nextState = wordAccess ? EXECUTE_I : FETCH;
					default:        nextState = FETCH;
				endcase
			end
			EXECUTE_R: begin
				nextState = MEMORY;
			end
			EXECUTE_I: begin
				nextState = (opCode == OPCODE_STORE) ? MEMORY_STORE : MEMORY;
			end
			MEMORY: begin
				if (opCode == OPCODE_LOAD) begin
					addrSrc   = ADDR_SRC_ALU;
					nextState = WRITEBACK_MEM;
				end else begin
					nextState = WRITEBACK;
				end
			end
			MEMORY_STORE: begin
				addrSrc   = ADDR_SRC_ALU;
				memWe     = 1'b1;
				nextState = FETCH;
			end
			WRITEBACK: begin
				regWrite  = 1'b1;
				nextState = FETCH;
			end
			WRITEBACK_MEM: begin
				// Same address keeps the data register stable
				addrSrc   = ADDR_SRC_ALU;
				wbSrc     = WB_SRC_MEM;
				regWrite  = 1'b1;
				nextState = FETCH;
			end
			default: begin
				nextState = FETCH;
			end
		endcase
	end

	////////////////////////////////////////
	// Checks
	////////////////////////////////////////

	stateLegal: assert property (@(posedge clk) disable iff (!arstN)
		state inside {FETCH, DECODE, EXECUTE_R, EXECUTE_I, MEMORY, MEMORY_STORE,
			WRITEBACK, WRITEBACK_MEM});

	// Stores only after a word store was decoded
	storeOnlyInStore: assert property (@(posedge clk) disable iff (!arstN)
		memWe |-> (state == MEMORY_STORE) && (opCode == OPCODE_STORE));

	noRegWriteOnStore: assert property (@(posedge clk) disable iff (!arstN)
		!(regWrite && memWe));

endmodule

// ==== source/cpuDatapath.sv ====
`timescale 1ns/1ps

module cpuDatapath
	import isaPkg::*, ctrlPkg::*;
#(
	parameter word_t ResetPc = '0
) (
	input  logic     clk,
	input  logic     arstN,
	input  logic     pcWrite,
	input  logic     irWrite,
	input  logic     regWrite,
	input  logic     aluOverride,
	input  logic     aluRegForm,
	input  aluSrcA_t aluSrcA,
	input  aluSrcB_t aluSrcB,
	input  addrSrc_t addrSrc,
	input  wbSrc_t   wbSrc,
	input  word_t    memRdata,
	output word_t    memAddr,
	output word_t    memWdata,
	output opcode_t  opCode,
	output funct3_t  funct3
);

	word_t  pc;
	instr_u ir;
	word_t  aluOut;
	word_t  mdr;
	word_t  imm;
	word_t  rs1Data;
	word_t  rs2Data;
	word_t  aluA;
	word_t  aluB;
	word_t  aluResult;
	word_t  wbData;

	////////////////////////////////////////
	// State registers
	////////////////////////////////////////

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			pc <= ResetPc;
		end else if (pcWrite) begin
			pc <= aluOut;
		end
	end

	// Payload registers
	always_ff @(posedge clk) begin
		if (irWrite) begin
			ir <= instr_u'(memRdata);
		end
		aluOut <= aluResult;
		mdr    <= memRdata;
	end

	assign opCode = ir.rType.opcode;
	assign funct3 = ir.rType.funct3;

	// S format only for stores
	always_comb begin
		if (ir.rType.opcode == OPCODE_STORE) begin
			imm = {{20{ir.sType.immHi[6]}}, ir.sType.immHi, ir.sType.immLo};
		end else begin
			imm = {{20{ir.iType.imm[11]}}, ir.iType.imm};
		end
	end

	////////////////////////////////////////
	// Operand and result muxes
	////////////////////////////////////////

	assign aluA = (aluSrcA == ALU_SRC_A_PC) ? pc : rs1Data;

	always_comb begin
		case (aluSrcB)
			ALU_SRC_B_RS2:  aluB = rs2Data;
			ALU_SRC_B_FOUR: aluB = 32'd4;
			ALU_SRC_B_IMM:  aluB = imm;
			default:        aluB = rs2Data;
		endcase
	end

	assign wbData   = (wbSrc == WB_SRC_MEM) ? mdr : aluOut;
	assign memAddr  = (addrSrc == ADDR_SRC_ALU) ? aluOut : pc;
	assign memWdata = rs2Data;

	registerFile u_registerFile (
		.clk      (clk),
		.arstN    (arstN),
		.regWrite (regWrite),
		.rs1Addr  (ir.rType.rs1),
		.rs2Addr  (ir.rType.rs2),
		.rdAddr   (ir.rType.rd),
		.rdData   (wbData),
		.rs1Data  (rs1Data),
		.rs2Data  (rs2Data)
	);

	// Bit 30 picks sub and sra
	aluUnit u_aluUnit (
		.a           (aluA),
		.b           (aluB),
		.funct3      (ir.rType.funct3),
		.altBit      (ir.rType.funct7[5]),
		.aluRegForm  (aluRegForm),
		.aluOverride (aluOverride),
		.result      (aluResult)
	);

	addrAligned: assert property (@(posedge clk) disable iff (!arstN)
		memAddr[1:0] == 2'b00);

endmodule

// ==== source/multicycleCore.sv ====
`timescale 1ns/1ps

module multicycleCore
	import isaPkg::*, ctrlPkg::*;
#(
	parameter word_t ResetPc = '0
) (
	input  logic  clk,
	input  logic  arstN,
	input  word_t memRdata,
	output word_t memAddr,
	output word_t memWdata,
	output logic  memWe
);

	// Controller to datapath
	logic     pcWrite;
	logic     irWrite;
	logic     regWrite;
	logic     aluOverride;
	logic     aluRegForm;
	aluSrcA_t aluSrcA;
	aluSrcB_t aluSrcB;
	addrSrc_t addrSrc;
	wbSrc_t   wbSrc;

	// Datapath to controller
	opcode_t  opCode;
	funct3_t  funct3;

	mainController u_mainController (
		.clk         (clk),
		.arstN       (arstN),
		.opCode      (opCode),
		.funct3      (funct3),
		.pcWrite     (pcWrite),
		.irWrite     (irWrite),
		.regWrite    (regWrite),
		.memWe       (memWe),
		.aluOverride (aluOverride),
		.aluRegForm  (aluRegForm),
		.aluSrcA     (aluSrcA),
		.aluSrcB     (aluSrcB),
		.addrSrc     (addrSrc),
		.wbSrc       (wbSrc)
	);

	cpuDatapath #(
		.ResetPc (ResetPc)
	) u_cpuDatapath (
		.clk         (clk),
		.arstN       (arstN),
		.pcWrite     (pcWrite),
		.irWrite     (irWrite),
		.regWrite    (regWrite),
		.aluOverride (aluOverride),
		.aluRegForm  (aluRegForm),
		.aluSrcA     (aluSrcA),
		.aluSrcB     (aluSrcB),
		.addrSrc     (addrSrc),
		.wbSrc       (wbSrc),
		.memRdata    (memRdata),
		.memAddr     (memAddr),
		.memWdata    (memWdata),
		.opCode      (opCode),
		.funct3      (funct3)
	);

endmodule

// ==== verif/multicycleCoreTb.sv ====
`timescale 1ns/1ps

module multicycleCoreTb
	import isaPkg::*;
();

	localparam int    MemWords    = 256;
	localparam int    ClockPeriod = 10;
	localparam int    RowCycles   = 40;
	localparam word_t DataAddrA   = 32'h0000_0100;
	localparam word_t DataAddrB   = 32'h0000_0104;
	localparam word_t ResultAddr  = 32'h0000_03F0;
	// Reads like addi x3 if the opcode were ignored
	localparam word_t BogusWord   = {12'h123, 5'd1, 3'b000, 5'd3, 7'b1111111};

	logic  clk;
	logic  arstN;
	word_t memRdata;
	word_t memAddr;
	word_t memWdata;
	logic  memWe;

	word_t mem [0:MemWords-1];

	// Stimulus table, one entry per row in each queue
	string rowName[$];
	word_t rowInstr[$];
	word_t rowOpA[$];
	word_t rowOpB[$];
	logic  rowRandom[$];
	logic  rowBogus[$];

	logic        tableReady = 1'b0;
	logic [31:0] lfsrState;
	int          failCount;

	multicycleCore #(
		.ResetPc (32'h0000_0000)
	) u_multicycleCore (
		.clk      (clk),
		.arstN    (arstN),
		.memRdata (memRdata),
		.memAddr  (memAddr),
		.memWdata (memWdata),
		.memWe    (memWe)
	);

	always #5 clk = ~clk;

	////////////////////////////////////////
	// Memory model
	////////////////////////////////////////

	assign memRdata = mem[memAddr[9:2]];

	always @(posedge clk) begin
		if (memWe) begin
			mem[memAddr[9:2]] <= memWdata;
		end
	end

	////////////////////////////////////////
	// Instruction encoding
	////////////////////////////////////////

	// Register form, always x1 op x2
	function automatic word_t rTypeWord(input logic [6:0] funct7, input logic [2:0] f3,
			input logic [4:0] rd);
		return {funct7, 5'd2, 5'd1, f3, rd, 7'b0110011};
	endfunction

	function automatic word_t iTypeWord(input logic [11:0] imm, input logic [2:0] f3,
			input logic [4:0] rd);
		return {imm, 5'd1, f3, rd, 7'b0010011};
	endfunction

	function automatic word_t loadWord(input logic [4:0] rd, input logic [11:0] offset);
		return {offset, 5'd0, 3'b010, rd, 7'b0000011};
	endfunction

	// Offset split across both S immediate fields
	function automatic word_t storeWord(input logic [4:0] rs2, input logic [11:0] offset);
		return {offset[11:5], rs2, 5'd0, 3'b010, offset[4:0], 7'b0100011};
	endfunction

	////////////////////////////////////////
	// Random operands and reference
	////////////////////////////////////////

	// Fibonacci form, x^32 + x^22 + x^2 + x + 1
	function automatic logic lfsrStep();
		logic feedback;
		logic outBit;
		feedback  = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
		outBit    = lfsrState[31];
		lfsrState = {lfsrState[30:0], feedback};
		return outBit;
	endfunction

	function automatic word_t randomWord();
		word_t value;
		int    i;
		value = '0;
		for (i = 0; i < XLEN; i++) begin
			value = {value[XLEN-2:0], lfsrStep()};
		end
		return value;
	endfunction

	function automatic word_t expectedResult(input word_t instr, input word_t a, input word_t b);
		logic [4:0] rd;
		logic [2:0] f3;
		logic       alt;
		logic       regForm;
		word_t      opB;
		rd      = instr[11:7];
		f3      = instr[14:12];
		alt     = instr[30];
		regForm = (instr[6:0] == 7'b0110011);
		opB     = regForm ? b : {{20{instr[31]}}, instr[31:20]};
		// x0 always reads back as zero
		if (rd == 5'd0) begin
			return '0;
		end
		case (f3)
			3'b000:  return (regForm && alt) ? a - opB : a + opB;
			3'b001:  return a << opB[4:0];
			3'b010:  return {31'b0, $signed(a) < $signed(opB)};
			3'b011:  return {31'b0, a < opB};
			3'b100:  return a ^ opB;
			3'b101:  return alt ? word_t'($signed(a) >>> opB[4:0]) : a >> opB[4:0];
			3'b110:  return a | opB;
			default: return a & opB;
		endcase
	endfunction

	////////////////////////////////////////
	// Stimulus table
	////////////////////////////////////////

	function automatic void addRow(input string name, input word_t instr, input word_t a,
			input word_t b, input logic useRandom, input logic bogus);
		rowName.push_back(name);
		rowInstr.push_back(instr);
		rowOpA.push_back(a);
		rowOpB.push_back(b);
		rowRandom.push_back(useRandom);
		rowBogus.push_back(bogus);
	endfunction

	function automatic void buildTable();
		addRow("add rand", rTypeWord(7'h00, FUNCT3_ADD, 5'd3), '0, '0, 1'b1, 1'b0);
		addRow("add overflow", rTypeWord(7'h00, FUNCT3_ADD, 5'd3), 32'h7FFF_FFFF, 32'd1, 1'b0, 1'b0);
		addRow("sub rand", rTypeWord(7'h20, FUNCT3_ADD, 5'd3), '0, '0, 1'b1, 1'b0);
		addRow("sub below zero", rTypeWord(7'h20, FUNCT3_ADD, 5'd3), 32'd0, 32'd1, 1'b0, 1'b0);
		addRow("sll rand", rTypeWord(7'h00, FUNCT3_SLL, 5'd3), '0, '0, 1'b1, 1'b0);
		addRow("slt rand", rTypeWord(7'h00, FUNCT3_SLT, 5'd3), '0, '0, 1'b1, 1'b0);
		addRow("slt min", rTypeWord(7'h00, FUNCT3_SLT, 5'd3), 32'h8000_0000, 32'd1, 1'b0, 1'b0);
		addRow("sltu min", rTypeWord(7'h00, FUNCT3_SLTU, 5'd3), 32'h8000_0000, 32'd1, 1'b0, 1'b0);
		addRow("xor rand", rTypeWord(7'h00, FUNCT3_XOR, 5'd3), '0, '0, 1'b1, 1'b0);
		addRow("srl wide amount", rTypeWord(7'h00, FUNCT3_SRL, 5'd3), 32'h8000_0000, 32'h3F,
			1'b0, 1'b0);
		addRow("sra rand", rTypeWord(7'h20, FUNCT3_SRL, 5'd3), '0, '0, 1'b1, 1'b0);
		addRow("sra min", rTypeWord(7'h20, FUNCT3_SRL, 5'd3), 32'h8000_0000, 32'd4, 1'b0, 1'b0);
		addRow("or rand", rTypeWord(7'h00, FUNCT3_OR, 5'd3), '0, '0, 1'b1, 1'b0);
		addRow("and rand", rTypeWord(7'h00, FUNCT3_AND, 5'd3), '0, '0, 1'b1, 1'b0);
		// Immediate bit 10 lands on instruction bit 30
		addRow("addi bit30", iTypeWord(12'hC00, FUNCT3_ADD, 5'd3), '0, '0, 1'b1, 1'b0);
		addRow("slti negative", iTypeWord(12'hFFB, FUNCT3_SLT, 5'd3), 32'hFFFF_FFF0, '0,
			1'b0, 1'b0);
		addRow("sltiu all ones", iTypeWord(12'hFFF, FUNCT3_SLTU, 5'd3), '0, '0, 1'b1, 1'b0);
		addRow("xori invert", iTypeWord(12'hFFF, FUNCT3_XOR, 5'd3), '0, '0, 1'b1, 1'b0);
		addRow("ori zero", iTypeWord(12'h000, FUNCT3_OR, 5'd3), '0, '0, 1'b1, 1'b0);
		addRow("andi negative", iTypeWord(12'hF0F, FUNCT3_AND, 5'd3), '0, '0, 1'b1, 1'b0);
		addRow("slli", iTypeWord(12'h007, FUNCT3_SLL, 5'd3), '0, '0, 1'b1, 1'b0);
		addRow("srli min", iTypeWord(12'h003, FUNCT3_SRL, 5'd3), 32'h8000_0000, '0, 1'b0, 1'b0);
		addRow("srai min", iTypeWord(12'h409, FUNCT3_SRL, 5'd3), 32'h8000_0000, '0, 1'b0, 1'b0);
		addRow("add to x0", rTypeWord(7'h00, FUNCT3_ADD, 5'd0), '0, '0, 1'b1, 1'b0);
		addRow("xori to x0", iTypeWord(12'hFFF, FUNCT3_XOR, 5'd0), '0, '0, 1'b1, 1'b0);
		addRow("add with no-op", rTypeWord(7'h00, FUNCT3_ADD, 5'd3), '0, '0, 1'b1, 1'b1);
		addRow("srai with no-op", iTypeWord(12'h40C, FUNCT3_SRL, 5'd3), '0, '0, 1'b1, 1'b1);
	endfunction

	// Filler opcode 7F is never handled by the core
	task automatic fillMemory();
		int i;
		for (i = 0; i < MemWords; i++) begin
			mem[i] <= {8'hE7, i[7:0], ~i[7:0], 8'h7F};
		end
	endtask

	////////////////////////////////////////
	// Checks
	////////////////////////////////////////

	task automatic checkWord(input string testName, input string field, input word_t expected,
			input word_t actual);
		if (actual !== expected) begin
			failCount++;
			$display("mismatch %s %s: expected %08h, actual %08h", testName, field, expected,
				actual);
			$display("Testbench failed");
			$fatal(1, "stopped at the first error");
		end
	endtask

	task automatic checkCycles(input string testName, input int expected, input int actual);
		if (actual != expected) begin
			failCount++;
			$display("mismatch %s store cycle: expected %0d, actual %0d", testName, expected,
				actual);
			$display("Testbench failed");
			$fatal(1, "stopped at the first error");
		end
	endtask

	////////////////////////////////////////
	// Row sequence
	////////////////////////////////////////

	task automatic runRow(input int r);
		word_t opA;
		word_t opB;
		word_t expData;
		int    expCycles;
		int    cycle;
		int    slot;
		opA = rowRandom[r] ? randomWord() : rowOpA[r];
		opB = rowRandom[r] ? randomWord() : rowOpB[r];
		expData = expectedResult(rowInstr[r], opA, opB);
		// LW, LW, operation at 5 cycles each, SW at 4, no-op at 2
		expCycles = 5 + 5 + 5 + 4 + (rowBogus[r] ? 2 : 0);

		arstN = 1'b0;
		fillMemory();
		mem[0] <= loadWord(5'd1, DataAddrA[11:0]);
		mem[1] <= loadWord(5'd2, DataAddrB[11:0]);
		mem[2] <= rowInstr[r];
		slot   = 3;
		if (rowBogus[r]) begin
			mem[3] <= BogusWord;
			slot   = 4;
		end
		mem[slot] <= storeWord(rowInstr[r][11:7], ResultAddr[11:0]);
		mem[DataAddrA[9:2]] <= opA;
		mem[DataAddrB[9:2]] <= opB;

		repeat (4) @(posedge clk);
		#1;
		arstN = 1'b1;

		// Cycle 1 is the first fetch after reset
		cycle = 0;
		while (!memWe && cycle < RowCycles) begin
			@(negedge clk);
			cycle++;
		end
		if (!memWe) begin
			$display("row %s never wrote its result to memory", rowName[r]);
			$display("Testbench failed");
			$fatal(1, "missing store");
		end

		checkWord(rowName[r], "store address", ResultAddr, memAddr);
		checkWord(rowName[r], "store data", expData, memWdata);
		checkCycles(rowName[r], expCycles, cycle);

		@(posedge clk);
		#1;
		checkWord(rowName[r], "memory word", expData, mem[ResultAddr[9:2]]);
	endtask

	initial begin
		int r;
		clk       = 1'b0;
		arstN     = 1'b0;
		lfsrState = 32'd18;
		failCount = 0;
		fillMemory();
		buildTable();
		tableReady = 1'b1;

		@(posedge clk);
		#1;
		for (r = 0; r < rowName.size(); r++) begin
			runRow(r);
		end

		if (failCount == 0) begin
			$display("Testbench passed");
			$finish;
		end else begin
			$display("Testbench failed");
			$fatal(1, "errors were found");
		end
	end

	// Watchdog sized from the table length
	initial begin
		wait (tableReady);
		#(rowName.size() * RowCycles * ClockPeriod);
		$display("watchdog expired before all rows finished");
		$display("Testbench failed");
		$fatal(1, "timeout");
	end

endmodule

// ==== filelist.f ====
source/isaPkg.sv
source/ctrlPkg.sv
source/aluUnit.sv
source/registerFile.sv
source/mainController.sv
source/cpuDatapath.sv
source/multicycleCore.sv
verif/multicycleCoreTb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module multicycleCoreTb -f filelist.f

# The log decides the result, so a nonzero exit from the model is tolerated here
./obj_dir/VmulticycleCoreTb > sim.log 2>&1 || true
cat sim.log

if grep -q "Testbench failed" sim.log; then
	exit 1
fi
if ! grep -q "Testbench passed" sim.log; then
	exit 1
fi
